//--- logic/usb_proto_pkg.sv
`default_nettype none

package usb_proto_pkg;

  // Token PIDs
  localparam logic [3:0] PID_OUT   = 4'b0001;
  localparam logic [3:0] PID_IN    = 4'b1001;
  localparam logic [3:0] PID_SETUP = 4'b1101;

  // Data PIDs with the DATA0/DATA1 toggle in the top bit
  localparam logic [3:0] PID_DATA0 = 4'b0011;
  localparam logic [3:0] PID_DATA1 = 4'b1011;

  // Handshake PIDs
  localparam logic [3:0] PID_ACK   = 4'b0010;
  localparam logic [3:0] PID_NAK   = 4'b1010;

  // One PID word seen whole, or split into toggle and group
  typedef union packed {
    logic [3:0] code;
    struct packed {
      logic       toggle;
      logic [2:0] group;
    } parts;
  } usb_pid_u;

  // Encoder data multiplexer selects
  localparam logic [2:0] MUX_EP0      = 3'd0;
  localparam logic [2:0] MUX_BULK_OUT = 3'd1;
  localparam logic [2:0] MUX_BULK_IN  = 3'd2;
  localparam logic [2:0] MUX_NONE     = 3'd7;

  // Transaction states
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    // Receive DATAx from the host
    RECV = 3'd1,
    // Handshake to the host
    RESP = 3'd2,
    // Discard DATAx, then NAK
    DROP = 3'd3,
    // Endpoint data out to the encoder
    SEND = 3'd4,
    // Wait for a host handshake or the turnaround timer
    WAIT = 3'd5
  } trans_state_e;

  // Timer reload values, in clock cycles minus one
  localparam int TA_LIMIT_DEFAULT = 101;
  localparam int EP_LIMIT_DEFAULT = 23;

endpackage

`default_nettype wire

//--- logic/usb_proto_timer.sv
`timescale 1ns/10ps
`default_nettype none

module usb_proto_timer #(
  parameter int LIMIT = usb_proto_pkg::TA_LIMIT_DEFAULT
) (
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic start_i,
  input  wire logic stop_i,
  output logic      expired_o
);

  localparam int W = $clog2(LIMIT + 1);

  logic [W-1:0] count;
  logic [W:0]   count_next;
  logic         running;
  logic         expired_q;

  // Top bit flags the underflow
  assign count_next = {1'b0, count} - 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      running   <= 1'b0;
      expired_q <= 1'b0;
    end else if (start_i) begin
      running   <= 1'b1;
      expired_q <= 1'b0;
    end else if (running && (count_next[W] || stop_i)) begin
      // A bus event ends the wait without a timeout
      running   <= 1'b0;
      expired_q <= !stop_i;
    end else begin
      expired_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (start_i) begin
      count <= W'(LIMIT);
    end else if (running) begin
      count <= count_next[W-1:0];
    end
  end

  assign expired_o = expired_q;

endmodule

`default_nettype wire

//--- logic/usb_ep_select.sv
`timescale 1ns/10ps
`default_nettype none

module usb_ep_select #(
  parameter logic [3:0] BULK_OUT_EP = 4'd1,
  parameter logic [3:0] BULK_IN_EP  = 4'd2
) (
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       set_conf_i,
  input  wire logic       clr_conf_i,
  input  wire logic [6:0] usb_addr_i,
  input  wire logic       tok_recv_i,
  input  wire logic [6:0] tok_addr_i,
  input  wire logic [3:0] tok_endp_i,
  input  wire logic [3:0] usb_pid_i,
  input  wire logic       dec_actv_i,
  input  wire logic       crc_error_i,
  input  wire logic       hsk_recv_i,
  input  wire logic       hsk_sent_i,
  input  wire logic       timeout_i,
  input  wire logic       ep0_parity_i,
  input  wire logic       out_rx_rdy_i,
  input  wire logic       out_parity_i,
  input  wire logic       in_tx_rdy_i,
  input  wire logic       in_parity_i,
  output logic            tok_hit_o,
  output logic            out_sel_o,
  output logic            out_rdy_o,
  output logic            in_sel_o,
  output logic            in_rdy_o,
  output logic            toggle_ok_o,
  output logic            crc_err_o,
  output logic            in_toggle_o,
  output logic            ep0_select_o,
  output logic            out_select_o,
  output logic            in_select_o,
  output logic            out_finish_o,
  output logic            in_finish_o,
  output logic            out_cancel_o,
  output logic            in_cancel_o,
  output logic [2:0]      mux_select_o
);

  usb_proto_pkg::usb_pid_u pid;

  logic       out_en;
  logic       in_en;
  logic       ep0_sel_q;
  logic       out_sel_q;
  logic       in_sel_q;
  logic       end_q;
  logic       crc_err_q;
  logic       crc_ack_q;
  logic       toggle_q;
  logic       out_fin_q;
  logic       in_fin_q;
  logic       out_can_q;
  logic       in_can_q;
  logic [2:0] mux_sel_q;
  logic       is_data;
  logic       toggle_w;

  assign pid = usb_pid_i;

  assign tok_hit_o = tok_recv_i && (tok_addr_i == usb_addr_i);

  // Direction support for the token's endpoint
  assign out_sel_o = out_en && (tok_endp_i == BULK_OUT_EP);
  assign out_rdy_o = out_sel_o && out_rx_rdy_i;
  assign in_sel_o  = in_en && (tok_endp_i == BULK_IN_EP);
  assign in_rdy_o  = in_sel_o && in_tx_rdy_i;

  // Toggle for an outgoing DATAx packet
  assign in_toggle_o = (tok_endp_i == 4'h0) ? ep0_parity_i : in_parity_i;

  // Bulk endpoints only answer once configured
  always_ff @(posedge clock) begin
    if (reset || clr_conf_i) begin
      out_en <= 1'b0;
      in_en  <= 1'b0;
    end else if (set_conf_i) begin
      out_en <= (BULK_OUT_EP != 4'h0);
      in_en  <= (BULK_IN_EP != 4'h0);
    end
  end

  // One pulse per error burst from the decoder
  always_ff @(posedge clock) begin
    if (reset || !crc_error_i) begin
      crc_err_q <= 1'b0;
      crc_ack_q <= 1'b0;
    end else if (!crc_ack_q) begin
      crc_err_q <= 1'b1;
      crc_ack_q <= 1'b1;
    end else begin
      crc_err_q <= 1'b0;
    end
  end

  assign crc_err_o = crc_err_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      end_q <= 1'b1;
    end else begin
      end_q <= clr_conf_i || hsk_recv_i || hsk_sent_i || timeout_i || crc_err_q;
    end
  end

  // Selects hold from the token until the transaction ends
  always_ff @(posedge clock) begin
    if (reset || end_q) begin
      ep0_sel_q <= 1'b0;
      out_sel_q <= 1'b0;
      in_sel_q  <= 1'b0;
    end else if (tok_hit_o) begin
      case (tok_endp_i)
        4'h0: begin
          ep0_sel_q <= 1'b1;
          out_sel_q <= 1'b0;
          in_sel_q  <= 1'b0;
        end
        BULK_OUT_EP: begin
          ep0_sel_q <= 1'b0;
          out_sel_q <= out_en;
          in_sel_q  <= 1'b0;
        end
        BULK_IN_EP: begin
          ep0_sel_q <= 1'b0;
          out_sel_q <= 1'b0;
          in_sel_q  <= in_en;
        end
        default: begin
          ep0_sel_q <= 1'b0;
          out_sel_q <= 1'b0;
          in_sel_q  <= 1'b0;
        end
      endcase
    end
  end

  // Only DATA0/DATA1 carry a sequence bit
  assign is_data  = (pid.parts.group == usb_proto_pkg::PID_DATA0[2:0]);
  assign toggle_w = is_data &&
                    ((ep0_sel_q && (ep0_parity_i == pid.parts.toggle)) ||
                     (out_sel_q && (out_parity_i == pid.parts.toggle)));

  always_ff @(posedge clock) begin
    if (reset) begin
      toggle_q <= 1'b0;
    end else if (dec_actv_i) begin
      toggle_q <= toggle_w;
    end
  end

  assign toggle_ok_o = toggle_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_fin_q <= 1'b0;
      in_fin_q  <= 1'b0;
      out_can_q <= 1'b0;
      in_can_q  <= 1'b0;
      mux_sel_q <= usb_proto_pkg::MUX_NONE;
    end else begin
      // OUT completes on our ACK, IN on the host's ACK
      out_fin_q <= out_sel_q && out_rx_rdy_i && hsk_sent_i;
      in_fin_q  <= in_sel_q && hsk_recv_i;
      out_can_q <= out_sel_q && (crc_err_q || timeout_i);
      in_can_q  <= in_sel_q && (crc_err_q || timeout_i);
      if (tok_hit_o) begin
        case (tok_endp_i)
          4'h0:        mux_sel_q <= usb_proto_pkg::MUX_EP0;
          BULK_OUT_EP: mux_sel_q <= usb_proto_pkg::MUX_BULK_OUT;
          BULK_IN_EP:  mux_sel_q <= usb_proto_pkg::MUX_BULK_IN;
          default:     mux_sel_q <= usb_proto_pkg::MUX_NONE;
        endcase
      end
    end
  end

  assign ep0_select_o = ep0_sel_q;
  assign out_select_o = out_sel_q;
  assign in_select_o  = in_sel_q;
  assign out_finish_o = out_fin_q;
  assign in_finish_o  = in_fin_q;
  assign out_cancel_o = out_can_q;
  assign in_cancel_o  = in_can_q;
  assign mux_select_o = mux_sel_q;

endmodule

`default_nettype wire

//--- logic/usb_trans_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module usb_trans_fsm (
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       tok_hit_i,
  input  wire logic [3:0] usb_pid_i,
  input  wire logic [3:0] tok_endp_i,
  input  wire logic       out_sel_i,
  input  wire logic       out_rdy_i,
  input  wire logic       in_sel_i,
  input  wire logic       in_rdy_i,
  input  wire logic       toggle_ok_i,
  input  wire logic       in_toggle_i,
  input  wire logic       crc_err_i,
  input  wire logic       usb_recv_i,
  input  wire logic       eop_recv_i,
  input  wire logic       usb_sent_i,
  input  wire logic       hsk_recv_i,
  input  wire logic       hsk_sent_i,
  input  wire logic       ta_expired_i,
  input  wire logic       ep_expired_i,
  output logic            hsk_send_o,
  output logic [3:0]      ulpi_tuser_o,
  output logic            mux_enable_o,
  output logic            ta_start_o,
  output logic            ep_start_o,
  output logic            timeout_o
);

  usb_proto_pkg::usb_pid_u      pid;
  usb_proto_pkg::trans_state_e  state;
  usb_proto_pkg::trans_state_e  state_n;

  logic [3:0] pid_q;
  logic [3:0] pid_n;
  logic [3:0] data_pid;
  logic       ep0;
  logic       mux_q;
  logic       ta_start_q;
  logic       ep_start_q;
  logic       timeout_q;

  assign pid      = usb_pid_i;
  assign ep0      = (tok_endp_i == 4'h0);
  assign data_pid = in_toggle_i ? usb_proto_pkg::PID_DATA1 : usb_proto_pkg::PID_DATA0;

  always_comb begin
    state_n = state;
    pid_n   = pid_q;
    case (state)
      usb_proto_pkg::IDLE: begin
        if (tok_hit_i) begin
          case (pid.code)
            usb_proto_pkg::PID_SETUP: begin
              state_n = ep0 ? usb_proto_pkg::RECV : usb_proto_pkg::WAIT;
            end
            usb_proto_pkg::PID_OUT: begin
              if (ep0 || out_rdy_i) begin
                state_n = usb_proto_pkg::RECV;
              end else if (out_sel_i) begin
                state_n = usb_proto_pkg::DROP;
              end else begin
                state_n = usb_proto_pkg::WAIT;
              end
            end
            usb_proto_pkg::PID_IN: begin
              if (ep0 || in_rdy_i) begin
                state_n = usb_proto_pkg::SEND;
                pid_n   = data_pid;
              end else if (in_sel_i) begin
                state_n = usb_proto_pkg::RESP;
                pid_n   = usb_proto_pkg::PID_NAK;
              end else begin
                state_n = usb_proto_pkg::WAIT;
              end
            end
            default: state_n = usb_proto_pkg::WAIT;
          endcase
        end
      end
      usb_proto_pkg::RECV: begin
        if (usb_recv_i) begin
          // A repeated packet is silently dropped
          if (toggle_ok_i) begin
            state_n = usb_proto_pkg::RESP;
            pid_n   = usb_proto_pkg::PID_ACK;
          end else begin
            state_n = usb_proto_pkg::IDLE;
          end
        end else if (timeout_q || crc_err_i) begin
          state_n = usb_proto_pkg::IDLE;
        end
      end
      usb_proto_pkg::DROP: begin
        if (eop_recv_i) begin
          state_n = usb_proto_pkg::RESP;
          pid_n   = usb_proto_pkg::PID_NAK;
        end
      end
      usb_proto_pkg::SEND: begin
        pid_n = data_pid;
        if (usb_sent_i) begin
          state_n = usb_proto_pkg::WAIT;
        end else if (timeout_q) begin
          state_n = usb_proto_pkg::IDLE;
        end
      end
      usb_proto_pkg::RESP: begin
        if (hsk_sent_i || timeout_q) begin
          state_n = usb_proto_pkg::IDLE;
        end
      end
      usb_proto_pkg::WAIT: begin
        if (hsk_recv_i || timeout_q) begin
          state_n = usb_proto_pkg::IDLE;
        end
      end
      default: state_n = usb_proto_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= usb_proto_pkg::IDLE;
      pid_q      <= 4'h0;
      mux_q      <= 1'b0;
      ta_start_q <= 1'b0;
      ep_start_q <= 1'b0;
      timeout_q  <= 1'b0;
    end else begin
      state <= state_n;
      pid_q <= pid_n;
      mux_q <= (state == usb_proto_pkg::SEND);
      // Turnaround timer guards every wait on the host
      ta_start_q <= (state_n == usb_proto_pkg::WAIT) && (state != usb_proto_pkg::WAIT);
      // Response timer guards host data and endpoint data
      ep_start_q <= ((state_n == usb_proto_pkg::RECV) && (state != usb_proto_pkg::RECV)) ||
                    ((state_n == usb_proto_pkg::SEND) && (state != usb_proto_pkg::SEND));
      timeout_q  <= ta_expired_i || ep_expired_i;
    end
  end

  assign hsk_send_o   = (state == usb_proto_pkg::RESP);
  assign ulpi_tuser_o = pid_q;
  assign mux_enable_o = mux_q;
  assign ta_start_o   = ta_start_q;
  assign ep_start_o   = ep_start_q;
  assign timeout_o    = timeout_q;

endmodule

`default_nettype wire

//--- logic/usb_protocol.sv
`timescale 1ns/10ps
`default_nettype none

module usb_protocol #(
  parameter logic [3:0] BULK_OUT_EP = 4'd1,
  parameter logic [3:0] BULK_IN_EP  = 4'd2,
  parameter int         TA_LIMIT    = usb_proto_pkg::TA_LIMIT_DEFAULT,
  parameter int         EP_LIMIT    = usb_proto_pkg::EP_LIMIT_DEFAULT
) (
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       set_conf_i,
  input  wire logic       clr_conf_i,
  input  wire logic [6:0] usb_addr_i,
  // Packet decoder
  input  wire logic       dec_actv_i,
  input  wire logic       crc_error_i,
  input  wire logic       hsk_recv_i,
  input  wire logic       usb_recv_i,
  input  wire logic [3:0] usb_pid_i,
  input  wire logic       eop_recv_i,
  input  wire logic       tok_recv_i,
  input  wire logic [6:0] tok_addr_i,
  input  wire logic [3:0] tok_endp_i,
  // Packet encoder
  output logic            hsk_send_o,
  input  wire logic       hsk_sent_i,
  input  wire logic       usb_busy_i,
  input  wire logic       usb_sent_i,
  output logic            mux_enable_o,
  output logic [2:0]      mux_select_o,
  output logic [3:0]      ulpi_tuser_o,
  output logic            timedout_o,
  // Control endpoint
  output logic            ep0_select_o,
  input  wire logic       ep0_parity_i,
  // Bulk OUT endpoint
  input  wire logic       out_rx_rdy_i,
  input  wire logic       out_parity_i,
  output logic            out_select_o,
  output logic            out_finish_o,
  output logic            out_cancel_o,
  // Bulk IN endpoint
  input  wire logic       in_tx_rdy_i,
  input  wire logic       in_parity_i,
  output logic            in_select_o,
  output logic            in_finish_o,
  output logic            in_cancel_o
);

  logic tok_hit;
  logic out_sel;
  logic out_rdy;
  logic in_sel;
  logic in_rdy;
  logic toggle_ok;
  logic in_toggle;
  logic crc_err;
  logic ta_start;
  logic ep_start;
  logic ta_expired;
  logic ep_expired;

  usb_ep_select #(
    .BULK_OUT_EP (BULK_OUT_EP),
    .BULK_IN_EP  (BULK_IN_EP)
  ) i_ep_select (
    .clock        (clock),
    .reset        (reset),
    .set_conf_i   (set_conf_i),
    .clr_conf_i   (clr_conf_i),
    .usb_addr_i   (usb_addr_i),
    .tok_recv_i   (tok_recv_i),
    .tok_addr_i   (tok_addr_i),
    .tok_endp_i   (tok_endp_i),
    .usb_pid_i    (usb_pid_i),
    .dec_actv_i   (dec_actv_i),
    .crc_error_i  (crc_error_i),
    .hsk_recv_i   (hsk_recv_i),
    .hsk_sent_i   (hsk_sent_i),
    .timeout_i    (timedout_o),
    .ep0_parity_i (ep0_parity_i),
    .out_rx_rdy_i (out_rx_rdy_i),
    .out_parity_i (out_parity_i),
    .in_tx_rdy_i  (in_tx_rdy_i),
    .in_parity_i  (in_parity_i),
    .tok_hit_o    (tok_hit),
    .out_sel_o    (out_sel),
    .out_rdy_o    (out_rdy),
    .in_sel_o     (in_sel),
    .in_rdy_o     (in_rdy),
    .toggle_ok_o  (toggle_ok),
    .crc_err_o    (crc_err),
    .in_toggle_o  (in_toggle),
    .ep0_select_o (ep0_select_o),
    .out_select_o (out_select_o),
    .in_select_o  (in_select_o),
    .out_finish_o (out_finish_o),
    .in_finish_o  (in_finish_o),
    .out_cancel_o (out_cancel_o),
    .in_cancel_o  (in_cancel_o),
    .mux_select_o (mux_select_o)
  );

  usb_trans_fsm i_trans_fsm (
    .clock        (clock),
    .reset        (reset),
    .tok_hit_i    (tok_hit),
    .usb_pid_i    (usb_pid_i),
    .tok_endp_i   (tok_endp_i),
    .out_sel_i    (out_sel),
    .out_rdy_i    (out_rdy),
    .in_sel_i     (in_sel),
    .in_rdy_i     (in_rdy),
    .toggle_ok_i  (toggle_ok),
    .in_toggle_i  (in_toggle),
    .crc_err_i    (crc_err),
    .usb_recv_i   (usb_recv_i),
    .eop_recv_i   (eop_recv_i),
    .usb_sent_i   (usb_sent_i),
    .hsk_recv_i   (hsk_recv_i),
    .hsk_sent_i   (hsk_sent_i),
    .ta_expired_i (ta_expired),
    .ep_expired_i (ep_expired),
    .hsk_send_o   (hsk_send_o),
    .ulpi_tuser_o (ulpi_tuser_o),
    .mux_enable_o (mux_enable_o),
    .ta_start_o   (ta_start),
    .ep_start_o   (ep_start),
    .timeout_o    (timedout_o)
  );

  // Host handshake must follow within the turnaround time
  usb_proto_timer #(
    .LIMIT (TA_LIMIT)
  ) i_ta_timer (
    .clock     (clock),
    .reset     (reset),
    .start_i   (ta_start),
    .stop_i    (hsk_recv_i),
    .expired_o (ta_expired)
  );

  // Either bus direction going active ends the response wait
  usb_proto_timer #(
    .LIMIT (EP_LIMIT)
  ) i_ep_timer (
    .clock     (clock),
    .reset     (reset),
    .start_i   (ep_start),
    .stop_i    (usb_busy_i | dec_actv_i),
    .expired_o (ep_expired)
  );

endmodule

`default_nettype wire

//--- dv/usb_protocol_properties.sv
`timescale 1ns/10ps
`default_nettype none

module usb_protocol_properties (
  input wire logic clock,
  input wire logic reset,
  input wire logic hsk_send_o,
  input wire logic mux_enable_o,
  input wire logic ep0_select_o,
  input wire logic out_select_o,
  input wire logic in_select_o,
  input wire logic out_finish_o,
  input wire logic in_finish_o
);

  int failures = 0;

  // Handshake and data never go to the encoder together
  hsk_mux_excl: assert property (@(posedge clock) disable iff (reset)
    !(hsk_send_o && mux_enable_o))
    else begin
      $error("hsk_send_o and mux_enable_o high together");
      failures++;
    end

  // One endpoint at a time
  select_onehot: assert property (@(posedge clock) disable iff (reset)
    $onehot0({ep0_select_o, out_select_o, in_select_o}))
    else begin
      $error("more than one endpoint select high");
      failures++;
    end

  out_finish_pulse: assert property (@(posedge clock) disable iff (reset)
    out_finish_o |=> !out_finish_o)
    else begin
      $error("out_finish_o longer than one cycle");
      failures++;
    end

  in_finish_pulse: assert property (@(posedge clock) disable iff (reset)
    in_finish_o |=> !in_finish_o)
    else begin
      $error("in_finish_o longer than one cycle");
      failures++;
    end

  // Registered outputs settle low while reset is held
  reset_quiet: assert property (@(posedge clock)
    reset |=> !(ep0_select_o || out_select_o || in_select_o || hsk_send_o || mux_enable_o))
    else begin
      $error("outputs active during reset");
      failures++;
    end

endmodule

bind usb_protocol usb_protocol_properties i_props (.*);

`default_nettype wire

//--- dv/tb_usb_protocol.sv
`timescale 1ns/10ps
`default_nettype none

module tb_usb_protocol;

  localparam logic [3:0] OUT_EP   = 4'd1;
  localparam logic [3:0] IN_EP    = 4'd2;
  localparam logic [6:0] DEV_ADDR = 7'h05;

  // Expected outcomes
  localparam logic [2:0] OC_ACK     = 3'd0;
  localparam logic [2:0] OC_NAK     = 3'd1;
  localparam logic [2:0] OC_DATA    = 3'd2;
  localparam logic [2:0] OC_SILENT  = 3'd3;
  localparam logic [2:0] OC_TIMEOUT = 3'd4;
  localparam logic [2:0] OC_CANCEL  = 3'd5;

  // Signals watched by the bounded waits
  localparam int SIG_HSK     = 0;
  localparam int SIG_MUX     = 1;
  localparam int SIG_TIMEOUT = 2;
  localparam int SIG_OUT_CAN = 3;

  typedef struct packed {
    logic       conf;
    logic [3:0] pid;
    logic [6:0] addr;
    logic [3:0] endp;
    logic       rdy;
    logic       parity;
    logic       toggle;
    logic       crc;
    logic [2:0] outcome;
  } row_t;

  logic       clock;
  logic       reset;
  logic       set_conf_i;
  logic       clr_conf_i;
  logic [6:0] usb_addr_i;
  logic       dec_actv_i;
  logic       crc_error_i;
  logic       hsk_recv_i;
  logic       usb_recv_i;
  logic [3:0] usb_pid_i;
  logic       eop_recv_i;
  logic       tok_recv_i;
  logic [6:0] tok_addr_i;
  logic [3:0] tok_endp_i;
  logic       hsk_send_o;
  logic       hsk_sent_i;
  logic       usb_busy_i;
  logic       usb_sent_i;
  logic       mux_enable_o;
  logic [2:0] mux_select_o;
  logic [3:0] ulpi_tuser_o;
  logic       timedout_o;
  logic       ep0_select_o;
  logic       ep0_parity_i;
  logic       out_rx_rdy_i;
  logic       out_parity_i;
  logic       out_select_o;
  logic       out_finish_o;
  logic       out_cancel_o;
  logic       in_tx_rdy_i;
  logic       in_parity_i;
  logic       in_select_o;
  logic       in_finish_o;
  logic       in_cancel_o;

  row_t   rows[$];
  logic   conf;
  logic   rnd_par;
  logic   rnd_tog;
  integer seed;
  int     mismatches;
  int     timeouts;
  int     other_errors;
  int     assert_failures;

  usb_protocol #(
    .BULK_OUT_EP (OUT_EP),
    .BULK_IN_EP  (IN_EP),
    .TA_LIMIT    (20),
    .EP_LIMIT    (10)
  ) i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Advance to just after the next rising edge
  task automatic step();
    @(posedge clock);
    #2;
  endtask

  task automatic check_val(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (exp !== act) begin
      mismatches++;
      $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  function automatic logic sig_value(input int which);
    case (which)
      SIG_HSK:     return hsk_send_o;
      SIG_MUX:     return mux_enable_o;
      SIG_TIMEOUT: return timedout_o;
      default:     return out_cancel_o;
    endcase
  endfunction

  task automatic wait_for(input int which, input string what);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 200) begin
      if (sig_value(which) === 1'b1) begin
        seen = 1'b1;
      end else begin
        step();
        n++;
      end
    end
    if (!seen) begin
      timeouts++;
      $display("ERROR t=%0t: %s never came within 200 cycles", $time, what);
    end
  endtask

  // Outcome from the transaction rules
  function automatic logic [2:0] predict(input logic c, input logic [3:0] pid,
                                         input logic [6:0] addr, input logic [3:0] endp,
                                         input logic rdy, input logic par,
                                         input logic tog, input logic crc);
    logic ep0;
    logic outsel;
    logic insel;
    logic rx;
    ep0    = (endp == 4'h0);
    outsel = c && (endp == OUT_EP);
    insel  = c && (endp == IN_EP);
    rx     = 1'b0;
    if (addr != DEV_ADDR) begin
      return OC_SILENT;
    end
    if (pid == usb_proto_pkg::PID_SETUP) begin
      if (!ep0) return OC_TIMEOUT;
      rx = 1'b1;
    end else if (pid == usb_proto_pkg::PID_OUT) begin
      if (ep0 || (outsel && rdy)) rx = 1'b1;
      else if (outsel) return OC_NAK;
      else return OC_TIMEOUT;
    end else begin
      if (ep0 || (insel && rdy)) return OC_DATA;
      else if (insel) return OC_NAK;
      else return OC_TIMEOUT;
    end
    if (crc) return OC_CANCEL;
    return (tog == par) ? OC_ACK : OC_SILENT;
  endfunction

  task automatic add_row(input logic c, input logic [3:0] pid, input logic [6:0] addr,
                         input logic [3:0] endp, input logic rdy, input logic par,
                         input logic tog, input logic crc);
    row_t r;
    r.conf    = c;
    r.pid     = pid;
    r.addr    = addr;
    r.endp    = endp;
    r.rdy     = rdy;
    r.parity  = par;
    r.toggle  = tog;
    r.crc     = crc;
    r.outcome = predict(c, pid, addr, endp, rdy, par, tog, crc);
    rows.push_back(r);
  endtask

  task automatic set_config(input logic c);
    if (c && !conf) begin
      set_conf_i = 1'b1;
      step();
      set_conf_i = 1'b0;
    end else if (!c && conf) begin
      clr_conf_i = 1'b1;
      step();
      clr_conf_i = 1'b0;
    end
    conf = c;
  endtask

  task automatic send_token(input logic [3:0] pid, input logic [6:0] addr,
                            input logic [3:0] endp);
    tok_addr_i = addr;
    tok_endp_i = endp;
    step();
    tok_recv_i = 1'b1;
    usb_pid_i  = pid;
    step();
    tok_recv_i = 1'b0;
    usb_pid_i  = 4'h0;
  endtask

  // DATAx packet from the host that ends in a good packet or a CRC error
  task automatic send_data(input logic tog, input logic crc);
    usb_pid_i  = tog ? usb_proto_pkg::PID_DATA1 : usb_proto_pkg::PID_DATA0;
    dec_actv_i = 1'b1;
    step();
    step();
    dec_actv_i = 1'b0;
    if (crc) begin
      crc_error_i = 1'b1;
    end else begin
      usb_recv_i = 1'b1;
      eop_recv_i = 1'b1;
    end
    step();
    crc_error_i = 1'b0;
    usb_recv_i  = 1'b0;
    eop_recv_i  = 1'b0;
    usb_pid_i   = 4'h0;
  endtask

  task automatic finish_handshake();
    hsk_sent_i = 1'b1;
    step();
    hsk_sent_i = 1'b0;
    check_val("hsk_send_o", 4'h0, hsk_send_o);
  endtask

  task automatic run_row(input row_t r);
    logic       bad;
    logic [3:0] exp_data;
    bad      = 1'b0;
    exp_data = r.parity ? usb_proto_pkg::PID_DATA1 : usb_proto_pkg::PID_DATA0;
    set_config(r.conf);
    out_rx_rdy_i = r.rdy;
    in_tx_rdy_i  = r.rdy;
    ep0_parity_i = r.parity;
    out_parity_i = r.parity;
    in_parity_i  = r.parity;
    send_token(r.pid, r.addr, r.endp);
    if (r.addr == DEV_ADDR) begin
      check_val("ep0_select_o", 4'(r.endp == 4'h0), ep0_select_o);
      check_val("out_select_o", 4'(r.conf && r.endp == OUT_EP), out_select_o);
      check_val("in_select_o", 4'(r.conf && r.endp == IN_EP), in_select_o);
    end
    case (r.outcome)
      OC_ACK: begin
        send_data(r.toggle, 1'b0);
        wait_for(SIG_HSK, "ACK handshake request");
        check_val("ulpi_tuser_o", usb_proto_pkg::PID_ACK, ulpi_tuser_o);
        finish_handshake();
        check_val("out_finish_o", 4'(r.endp == OUT_EP), out_finish_o);
        step();
        check_val("out_finish_o", 4'h0, out_finish_o);
      end
      OC_NAK: begin
        if (r.pid == usb_proto_pkg::PID_OUT) begin
          send_data(r.toggle, 1'b0);
          wait_for(SIG_HSK, "NAK handshake request");
        end else begin
          // An IN NAK starts on the token edge
          check_val("hsk_send_o", 4'h1, hsk_send_o);
          check_val("mux_enable_o", 4'h0, mux_enable_o);
        end
        check_val("ulpi_tuser_o", usb_proto_pkg::PID_NAK, ulpi_tuser_o);
        finish_handshake();
      end
      OC_DATA: begin
        wait_for(SIG_MUX, "mux enable");
        check_val("mux_select_o",
                  (r.endp == 4'h0) ? usb_proto_pkg::MUX_EP0 : usb_proto_pkg::MUX_BULK_IN,
                  mux_select_o);
        check_val("ulpi_tuser_o", exp_data, ulpi_tuser_o);
        usb_busy_i = 1'b1;
        step();
        step();
        usb_busy_i = 1'b0;
        usb_sent_i = 1'b1;
        step();
        usb_sent_i = 1'b0;
        step();
        step();
        hsk_recv_i = 1'b1;
        step();
        hsk_recv_i = 1'b0;
        check_val("in_finish_o", 4'(r.endp == IN_EP), in_finish_o);
      end
      OC_SILENT: begin
        if (r.addr == DEV_ADDR) begin
          send_data(r.toggle, 1'b0);
        end
        repeat (30) begin
          if (hsk_send_o || mux_enable_o || timedout_o) bad = 1'b1;
          step();
        end
        if (bad) begin
          other_errors++;
          $display("ERROR t=%0t: ignored transaction still drove an output", $time);
        end
      end
      OC_TIMEOUT: begin
        wait_for(SIG_TIMEOUT, "timedout_o pulse");
        check_val("hsk_send_o", 4'h0, hsk_send_o);
      end
      default: begin
        send_data(r.toggle, 1'b1);
        wait_for(SIG_OUT_CAN, "out_cancel_o pulse");
        check_val("hsk_send_o", 4'h0, hsk_send_o);
      end
    endcase
    repeat (4) step();
  endtask

  // Selects drop two edges after clr_conf_i
  task automatic check_conf_clear();
    set_config(1'b1);
    out_rx_rdy_i = 1'b1;
    send_token(usb_proto_pkg::PID_OUT, DEV_ADDR, OUT_EP);
    check_val("out_select_o", 4'h1, out_select_o);
    clr_conf_i = 1'b1;
    step();
    clr_conf_i = 1'b0;
    conf       = 1'b0;
    step();
    check_val("out_select_o", 4'h0, out_select_o);
    wait_for(SIG_TIMEOUT, "timedout_o after configuration clear");
    repeat (4) step();
  endtask

  initial begin
    reset           = 1'b1;
    set_conf_i      = 1'b0;
    clr_conf_i      = 1'b0;
    usb_addr_i      = DEV_ADDR;
    dec_actv_i      = 1'b0;
    crc_error_i     = 1'b0;
    hsk_recv_i      = 1'b0;
    usb_recv_i      = 1'b0;
    usb_pid_i       = 4'h0;
    eop_recv_i      = 1'b0;
    tok_recv_i      = 1'b0;
    tok_addr_i      = 7'h00;
    tok_endp_i      = 4'h0;
    hsk_sent_i      = 1'b0;
    usb_busy_i      = 1'b0;
    usb_sent_i      = 1'b0;
    ep0_parity_i    = 1'b0;
    out_rx_rdy_i    = 1'b0;
    out_parity_i    = 1'b0;
    in_tx_rdy_i     = 1'b0;
    in_parity_i     = 1'b0;
    conf            = 1'b0;
    rnd_par         = 1'b0;
    rnd_tog         = 1'b0;
    seed            = 32'h4b6a_1b0a;
    mismatches      = 0;
    timeouts        = 0;
    other_errors    = 0;
    assert_failures = 0;

    add_row(0, usb_proto_pkg::PID_OUT,   DEV_ADDR, OUT_EP, 1, 0, 0, 0);
    add_row(1, usb_proto_pkg::PID_OUT,   DEV_ADDR, OUT_EP, 1, 0, 0, 0);
    add_row(1, usb_proto_pkg::PID_OUT,   DEV_ADDR, OUT_EP, 1, 1, 0, 0);
    add_row(1, usb_proto_pkg::PID_OUT,   DEV_ADDR, OUT_EP, 0, 0, 0, 0);
    add_row(1, usb_proto_pkg::PID_IN,    DEV_ADDR, IN_EP,  0, 0, 0, 0);
    add_row(1, usb_proto_pkg::PID_IN,    DEV_ADDR, IN_EP,  1, 1, 0, 0);
    add_row(1, usb_proto_pkg::PID_IN,    DEV_ADDR, IN_EP,  1, 0, 0, 0);
    add_row(1, usb_proto_pkg::PID_OUT,   7'h06,    OUT_EP, 1, 0, 0, 0);
    add_row(1, usb_proto_pkg::PID_IN,    DEV_ADDR, 4'd5,   1, 0, 0, 0);
    add_row(1, usb_proto_pkg::PID_OUT,   DEV_ADDR, OUT_EP, 1, 0, 0, 1);
    add_row(1, usb_proto_pkg::PID_SETUP, DEV_ADDR, 4'd0,   1, 0, 0, 0);
    add_row(1, usb_proto_pkg::PID_SETUP, DEV_ADDR, OUT_EP, 1, 0, 0, 0);
    add_row(1, usb_proto_pkg::PID_IN,    DEV_ADDR, 4'd0,   1, 1, 0, 0);
    // Extra rows with random sequence bits
    repeat (3) begin
      rnd_par = 1'($random(seed));
      rnd_tog = 1'($random(seed));
      add_row(1, usb_proto_pkg::PID_OUT, DEV_ADDR, OUT_EP, 1, rnd_par, rnd_tog, 0);
      rnd_par = 1'($random(seed));
      add_row(1, usb_proto_pkg::PID_IN, DEV_ADDR, IN_EP, 1, rnd_par, 0, 0);
    end

    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    repeat (3) begin
      check_val("hsk_send_o", 4'h0, hsk_send_o);
      check_val("mux_enable_o", 4'h0, mux_enable_o);
      check_val("timedout_o", 4'h0, timedout_o);
      check_val("selects", 4'h0, {ep0_select_o, out_select_o, in_select_o});
      check_val("finish/cancel", 4'h0, {out_finish_o, in_finish_o, out_cancel_o, in_cancel_o});
      step();
    end

    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    check_conf_clear();

    assert_failures = i_dut.i_props.failures;
    $display("Summary: %0d mismatches, %0d timeouts, %0d errors, %0d assertion failures",
             mismatches, timeouts, other_errors, assert_failures);
    if (mismatches == 0 && timeouts == 0 && other_errors == 0 && assert_failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
logic/usb_proto_pkg.sv
logic/usb_proto_timer.sv
logic/usb_ep_select.sv
logic/usb_trans_fsm.sv
logic/usb_protocol.sv
dv/usb_protocol_properties.sv
dv/tb_usb_protocol.sv

//--- Bender.yml
package:
  name: usb_protocol

sources:
  - logic/usb_proto_pkg.sv
  - logic/usb_proto_timer.sv
  - logic/usb_ep_select.sv
  - logic/usb_trans_fsm.sv
  - logic/usb_protocol.sv
  - target: test
    files:
      - dv/usb_protocol_properties.sv
      - dv/tb_usb_protocol.sv
